//--- build.f
+incdir+design
design/img_pkg.sv
design/pixel_input.sv
design/frame_stats.sv
design/frame_ram.sv
design/capture_ctrl.sv
design/img_capture_top.sv
tb/tb_img_capture.sv

//--- design/capture_ctrl.sv
`timescale 1ns/100ps
`include "img_params.svh"

module capture_ctrl import img_pkg::*; (
    input  logic                        clk,
    input  logic                        fifoIn_rst,
    input  logic                        cmd_capture,
    input  logic [`IMG_HEADER_BITS-1:0] cmd_header,
    input  logic                        pix_write,
    input  pixel_word_t                 pix_word,
    input  logic                        done,
    input  logic [`IMG_COUNT_BITS-1:0]  pixel_count,
    input  logic                        readout_ready,
    input  logic                        readout_trigger,
    output logic                        arm,
    output ram_cmd_e                    ram_cmd,
    output logic                        write_trigger,
    output ram_word_u                   write_data,
    output logic                        capture_done
);

    localparam int HDR_CNT_W  = $clog2(`IMG_HEADER_WORDS + 1);
    localparam int READ_CNT_W = `IMG_COUNT_BITS + 1;

    ctrl_state_e                 state;
    logic [HDR_CNT_W-1:0]        hdr_cnt;
    logic [READ_CNT_W-1:0]       read_cnt;
    logic [`IMG_HEADER_BITS-1:0] hdr_sr;
    logic                        xfer;

    assign xfer = readout_ready && readout_trigger;

    // ========================================================================
    // Header shifter and write data
    // ========================================================================
    always_ff @(posedge clk) begin
        if (cmd_capture) begin
            hdr_sr <= cmd_header;
        end else if (state == ctrl_header) begin
            hdr_sr <= hdr_sr << 16;
        end

        // Most significant header word goes out first
        if (state == ctrl_header) begin
            write_data.raw <= hdr_sr[`IMG_HEADER_BITS-1 -: 16];
        end else if (state == ctrl_capture && pix_write) begin
            write_data.pix <= pix_word;
        end
    end

    // ========================================================================
    // Control FSM
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state         <= ctrl_idle;
            hdr_cnt       <= '0;
            read_cnt      <= '0;
            arm           <= 1'b0;
            ram_cmd       <= ram_cmd_none;
            write_trigger <= 1'b0;
            capture_done  <= 1'b0;
        end else begin
            // Strobes default low
            ram_cmd       <= ram_cmd_none;
            write_trigger <= 1'b0;
            arm           <= 1'b0;
            capture_done  <= 1'b0;

            case (state)
                ctrl_header: begin
                    if (hdr_cnt == HDR_CNT_W'(`IMG_HEADER_WORDS)) begin
                        // Header is in memory, start the pixel port
                        arm   <= 1'b1;
                        state <= ctrl_capture;
                    end else begin
                        write_trigger <= 1'b1;
                        hdr_cnt       <= hdr_cnt + 1'b1;
                    end
                end

                ctrl_capture: begin
                    write_trigger <= pix_write;
                    // done of the previous frame is still up while arm is out
                    if (done && !arm) begin
                        ram_cmd      <= ram_cmd_read;
                        capture_done <= 1'b1;
                        read_cnt     <= {1'b0, pixel_count} +
                                        READ_CNT_W'(`IMG_HEADER_WORDS);
                        state        <= ctrl_read_start;
                    end
                end

                // Read command is being taken by the memory
                ctrl_read_start: begin
                    state <= ctrl_readout;
                end

                ctrl_readout: begin
                    if (xfer) begin
                        read_cnt <= read_cnt - 1'b1;
                        if (read_cnt == READ_CNT_W'(1)) begin
                            ram_cmd <= ram_cmd_stop;
                            state   <= ctrl_idle;
                        end
                    end
                end

                default: begin
                end
            endcase

            // Restart from the header in any state
            if (cmd_capture) begin
                state         <= ctrl_header;
                hdr_cnt       <= '0;
                ram_cmd       <= ram_cmd_write;
                write_trigger <= 1'b0;
                arm           <= 1'b0;
                capture_done  <= 1'b0;
            end
        end
    end

endmodule

//--- design/frame_ram.sv
`timescale 1ns/100ps
`include "img_params.svh"

module frame_ram import img_pkg::*; (
    input  logic      clk,
    input  logic      fifoIn_rst,
    input  ram_cmd_e  ram_cmd,
    input  logic      write_trigger,
    input  ram_word_u write_data,
    output logic      readout_ready,
    input  logic      readout_trigger,
    output ram_word_u readout_data
);

    ram_word_u mem [0:`IMG_RAM_DEPTH-1];

    logic [`IMG_RAM_ADDR_BITS-1:0] wr_addr;
    logic [`IMG_RAM_ADDR_BITS-1:0] rd_addr;
    logic                          fetch;

    // ========================================================================
    // Memory array
    // ========================================================================
    always_ff @(posedge clk) begin
        if (write_trigger) begin
            mem[wr_addr] <= write_data;
        end
    end

    // Output register, held until the next fetch
    always_ff @(posedge clk) begin
        if (fetch) begin
            readout_data <= mem[rd_addr];
        end
    end

    // ========================================================================
    // Address counters and readout handshake
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            wr_addr       <= '0;
            rd_addr       <= '0;
            fetch         <= 1'b0;
            readout_ready <= 1'b0;
        end else begin
            if (write_trigger) begin
                wr_addr <= wr_addr + 1'b1;
            end

            // Word taken, fetch the next one
            if (readout_ready && readout_trigger) begin
                readout_ready <= 1'b0;
                fetch         <= 1'b1;
            end

            if (fetch) begin
                rd_addr       <= rd_addr + 1'b1;
                fetch         <= 1'b0;
                readout_ready <= 1'b1;
            end

            // Commands override the handshake
            case (ram_cmd)
                ram_cmd_write: begin
                    wr_addr       <= '0;
                    fetch         <= 1'b0;
                    readout_ready <= 1'b0;
                end
                ram_cmd_read: begin
                    rd_addr       <= '0;
                    fetch         <= 1'b1;
                    readout_ready <= 1'b0;
                end
                ram_cmd_stop: begin
                    fetch         <= 1'b0;
                    readout_ready <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- design/frame_stats.sv
`timescale 1ns/100ps
`include "img_params.svh"

module frame_stats import img_pkg::*; (
    input  logic          clk,
    input  logic          fifoIn_rst,
    input  logic          arm,
    input  pixel_in_t     pins_q,
    input  logic          pix_write,
    output frame_status_t status
);

    logic                       lv_prev;
    logic [1:0]                 col_phase;
    logic [1:0]                 line_phase;
    logic                       stat_en;
    logic [`IMG_PIXEL_BITS-1:0] stat_px;

    // Sampled pixel for the stats stage
    always_ff @(posedge clk) begin
        stat_px <= pins_q.d;
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            lv_prev    <= 1'b0;
            col_phase  <= 2'd0;
            line_phase <= 2'd0;
            stat_en    <= 1'b0;
            status     <= '0;
        end else begin
            lv_prev <= pins_q.lv;

            // 4x4 subsampling grid
            if (!pins_q.lv) col_phase <= 2'd0;
            else            col_phase <= col_phase + 2'd1;

            if (!pins_q.fv)                  line_phase <= 2'd0;
            else if (lv_prev && !pins_q.lv)  line_phase <= line_phase + 2'd1;

            stat_en <= pix_write && col_phase == 2'd0 && line_phase == 2'd0;

            if (pix_write) begin
                status.pixel_count <= status.pixel_count + 1'b1;
            end

            // Top 7 bits decide highlight or shadow
            if (stat_en) begin
                if (&stat_px[`IMG_PIXEL_BITS-1 -: 7]) begin
                    status.highlight_count <= status.highlight_count + 1'b1;
                end else if (~|stat_px[`IMG_PIXEL_BITS-1 -: 7]) begin
                    status.shadow_count <= status.shadow_count + 1'b1;
                end
            end

            if (arm) begin
                status <= '0;
            end
        end
    end

endmodule

//--- design/img_capture_top.sv
`timescale 1ns/100ps
`include "img_params.svh"

module img_capture_top import img_pkg::*; (
    input  logic                        clk,
    input  logic                        fifoIn_rst,
    input  logic                        cmd_capture,
    input  logic [`IMG_HEADER_BITS-1:0] cmd_header,
    input  pixel_in_t                   img,
    output logic                        readout_ready,
    input  logic                        readout_trigger,
    output logic [15:0]                 readout_data,
    output frame_status_t               status,
    output logic                        capture_done
);

    pixel_in_t   pins_q;
    logic        pix_write;
    pixel_word_t pix_word;
    logic        done;
    logic        arm;
    ram_cmd_e    ram_cmd;
    logic        write_trigger;
    ram_word_u   write_data;
    ram_word_u   rd_word;

    // Readout port shows the raw word view
    assign readout_data = rd_word.raw;

    // ========================================================================
    // Pixel path
    // ========================================================================
    pixel_input u_pixel_input (
        .clk        (clk),
        .fifoIn_rst (fifoIn_rst),
        .arm        (arm),
        .img        (img),
        .pins_q     (pins_q),
        .pix_write  (pix_write),
        .pix_word   (pix_word),
        .done       (done)
    );

    frame_stats u_frame_stats (
        .clk        (clk),
        .fifoIn_rst (fifoIn_rst),
        .arm        (arm),
        .pins_q     (pins_q),
        .pix_write  (pix_write),
        .status     (status)
    );

    // ========================================================================
    // Control and frame memory
    // ========================================================================
    capture_ctrl u_capture_ctrl (
        .clk             (clk),
        .fifoIn_rst      (fifoIn_rst),
        .cmd_capture     (cmd_capture),
        .cmd_header      (cmd_header),
        .pix_write       (pix_write),
        .pix_word        (pix_word),
        .done            (done),
        .pixel_count     (status.pixel_count),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger),
        .arm             (arm),
        .ram_cmd         (ram_cmd),
        .write_trigger   (write_trigger),
        .write_data      (write_data),
        .capture_done    (capture_done)
    );

    frame_ram u_frame_ram (
        .clk             (clk),
        .fifoIn_rst      (fifoIn_rst),
        .ram_cmd         (ram_cmd),
        .write_trigger   (write_trigger),
        .write_data      (write_data),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger),
        .readout_data    (rd_word)
    );

endmodule

//--- design/img_params.svh
`ifndef IMG_PARAMS_SVH
`define IMG_PARAMS_SVH

// Header supplied by the host, stored ahead of the pixels
`define IMG_HEADER_WORDS 8
`define IMG_HEADER_BITS (`IMG_HEADER_WORDS * 16)

// On-chip frame memory in 16-bit words
`define IMG_RAM_DEPTH 1024
`define IMG_RAM_ADDR_BITS $clog2(`IMG_RAM_DEPTH)

// Sensor sample width
`define IMG_PIXEL_BITS 12

// Width of each frame status counter
`define IMG_COUNT_BITS 18

`endif

//--- design/img_pkg.sv
`include "img_params.svh"

package img_pkg;

    // Sensor pins as seen on one clock edge
    typedef struct packed {
        logic                       fv;
        logic                       lv;
        logic [`IMG_PIXEL_BITS-1:0] d;
    } pixel_in_t;

    // Pixel as stored, pad is always zero
    typedef struct packed {
        logic [15-`IMG_PIXEL_BITS:0] pad;
        logic [`IMG_PIXEL_BITS-1:0]  value;
    } pixel_word_t;

    // Frame memory word, a header word or a pixel word
    typedef union packed {
        logic [15:0] raw;
        pixel_word_t pix;
    } ram_word_u;

    typedef enum logic [1:0] {
        ram_cmd_none  = 2'd0,
        ram_cmd_write = 2'd1,
        ram_cmd_read  = 2'd2,
        ram_cmd_stop  = 2'd3
    } ram_cmd_e;

    typedef struct packed {
        logic [`IMG_COUNT_BITS-1:0] pixel_count;
        logic [`IMG_COUNT_BITS-1:0] highlight_count;
        logic [`IMG_COUNT_BITS-1:0] shadow_count;
    } frame_status_t;

    typedef enum logic [2:0] {
        ctrl_idle,
        ctrl_header,
        ctrl_capture,
        ctrl_read_start,
        ctrl_readout
    } ctrl_state_e;

    // Frame sync sequence of the pixel port
    typedef enum logic [1:0] {
        in_idle,
        in_wait_low,
        in_wait_high,
        in_write
    } in_state_e;

endpackage

//--- design/pixel_input.sv
`timescale 1ns/100ps

module pixel_input import img_pkg::*; (
    input  logic        clk,
    input  logic        fifoIn_rst,
    input  logic        arm,
    input  pixel_in_t   img,
    output pixel_in_t   pins_q,
    output logic        pix_write,
    output pixel_word_t pix_word,
    output logic        done
);

    in_state_e state;

    // ========================================================================
    // Pin register and frame sync
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            pins_q <= '0;
            state  <= in_idle;
            done   <= 1'b0;
        end else begin
            pins_q <= img;

            case (state)
                // Skip any frame already running
                in_wait_low: begin
                    if (!pins_q.fv) begin
                        state <= in_wait_high;
                    end
                end
                in_wait_high: begin
                    if (pins_q.fv) begin
                        state <= in_write;
                    end
                end
                in_write: begin
                    if (!pins_q.fv) begin
                        done  <= 1'b1;
                        state <= in_idle;
                    end
                end
                default: begin
                end
            endcase

            // A new arm restarts the sequence from any state
            if (arm) begin
                state <= in_wait_low;
                done  <= 1'b0;
            end
        end
    end

    // First valid sample is taken on the cycle the sequence sees fv rise
    assign pix_write = pins_q.fv && pins_q.lv &&
                       (state == in_wait_high || state == in_write);

    assign pix_word = '{pad: '0, value: pins_q.d};

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_img_capture -o tb_img_capture
./obj_dir/tb_img_capture | tee sim.log

if grep -qx "Test passed" sim.log; then
    exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

//--- tb/tb_img_capture.sv
`timescale 1ns/100ps
`include "img_params.svh"

module tb_img_capture import img_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int NUM_FRAMES   = 6;
    localparam int MAX_LINES    = 12;
    localparam int MAX_LINE_LEN = 20;
    localparam int MAX_LINE_GAP = 8;
    localparam int PIX_BITS     = `IMG_PIXEL_BITS;

    // Per frame bound, a skipped frame and a captured frame at full size
    localparam int FRAME_CYCLES = 2 * (`IMG_HEADER_WORDS + 12 +
                                       MAX_LINES * (MAX_LINE_LEN + MAX_LINE_GAP));
    localparam int MAX_WORDS    = `IMG_HEADER_WORDS + MAX_LINES * MAX_LINE_LEN;
    localparam int MARGIN       = 64;
    localparam longint WATCHDOG_CYCLES = longint'(NUM_FRAMES) *
        (`IMG_HEADER_WORDS + FRAME_CYCLES + 3 * MAX_WORDS + MARGIN);

    localparam int MODE_PLAIN   = 0;
    localparam int MODE_SKIP    = 1;
    localparam int MODE_RESTART = 2;

    logic                        clk;
    logic                        fifoIn_rst;
    logic                        cmd_capture;
    logic [`IMG_HEADER_BITS-1:0] cmd_header;
    pixel_in_t                   img;
    logic                        readout_ready;
    logic                        readout_trigger;
    logic [15:0]                 readout_data;
    frame_status_t               status;
    logic                        capture_done;

    // Reference model state
    logic [31:0]                 lfsr;
    logic [15:0]                 exp_q [$];
    int                          exp_pixels;
    int                          exp_high;
    int                          exp_shadow;
    logic                        pulse_req;
    logic [`IMG_HEADER_BITS-1:0] next_header;

    img_capture_top dut0 (
        .clk             (clk),
        .fifoIn_rst      (fifoIn_rst),
        .cmd_capture     (cmd_capture),
        .cmd_header      (cmd_header),
        .img             (img),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger),
        .readout_data    (readout_data),
        .status          (status),
        .capture_done    (capture_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    // ========================================================================
    // Random numbers and checking
    // ========================================================================
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Bias toward all-high and all-low top bits so both counters see hits
    function automatic logic [PIX_BITS-1:0] pick_pixel();
        logic [1:0] kind;
        kind = 2'(rand_bits(2));
        case (kind)
            2'd0:    return {7'h7f, (PIX_BITS-7)'(rand_bits(PIX_BITS - 7))};
            2'd1:    return {7'h00, (PIX_BITS-7)'(rand_bits(PIX_BITS - 7))};
            default: return PIX_BITS'(rand_bits(PIX_BITS));
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================
    task automatic drive_sample(input logic frame_v, input logic line_v,
                                input logic [PIX_BITS-1:0] pix);
        @(posedge clk);
        img         <= '{fv: frame_v, lv: line_v, d: pix};
        cmd_capture <= pulse_req;
        cmd_header  <= next_header;
        pulse_req    = 1'b0;
    endtask

    // Next sample carries the capture pulse, expected words start over
    task automatic request_capture();
        next_header = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
        pulse_req   = 1'b1;
        exp_q.delete();
        exp_pixels  = 0;
        exp_high    = 0;
        exp_shadow  = 0;
        for (int w = 0; w < `IMG_HEADER_WORDS; w++) begin
            exp_q.push_back(next_header[`IMG_HEADER_BITS-1-16*w -: 16]);
        end
    endtask

    task automatic record_pixel(input logic [PIX_BITS-1:0] pix, input int col, input int line);
        exp_q.push_back(16'(pix));
        exp_pixels++;
        if (col % 4 == 0 && line % 4 == 0) begin
            if (pix[PIX_BITS-1 -: 7] == 7'h7f) begin
                exp_high++;
            end else if (pix[PIX_BITS-1 -: 7] == 7'h00) begin
                exp_shadow++;
            end
        end
    endtask

    // Long enough for the header write and arm to finish with fv low
    task automatic blank_gap();
        int len;
        len = `IMG_HEADER_WORDS + 4 + int'(rand_bits(2));
        repeat (len) drive_sample(1'b0, 1'b0, '0);
    endtask

    task automatic drive_frame(input logic keep, input int min_porch);
        int                  n_lines;
        int                  len;
        int                  gap;
        logic [PIX_BITS-1:0] pix;
        n_lines = 1 + int'(rand_bits(4)) % MAX_LINES;
        gap     = min_porch + int'(rand_bits(2));
        repeat (gap) drive_sample(1'b1, 1'b0, pick_pixel());
        for (int j = 0; j < n_lines; j++) begin
            len = 2 + int'(rand_bits(5)) % (MAX_LINE_LEN - 1);
            for (int i = 0; i < len; i++) begin
                pix = pick_pixel();
                drive_sample(1'b1, 1'b1, pix);
                if (keep) begin
                    record_pixel(pix, i, j);
                end
            end
            // Blanking data with lv low must never be stored
            gap = 1 + int'(rand_bits(3));
            repeat (gap) drive_sample(1'b1, 1'b0, pick_pixel());
        end
        drive_sample(1'b0, 1'b0, '0);
    endtask

    // ========================================================================
    // Response checking
    // ========================================================================
    task automatic check_status();
        @(negedge clk);
        while (!capture_done) @(negedge clk);
        check_value("pixel_count", 32'(status.pixel_count), exp_pixels);
        check_value("highlight_count", 32'(status.highlight_count), exp_high);
        check_value("shadow_count", 32'(status.shadow_count), exp_shadow);
    endtask

    task automatic read_frame();
        int          stall;
        logic        waiting;
        logic [15:0] held;
        stall   = 0;
        waiting = 1'b0;
        held    = '0;
        while (exp_q.size() > 0) begin
            @(posedge clk);
            readout_trigger <= (stall == 0);
            @(negedge clk);
            // Held-off word must stay put
            if (waiting) begin
                check_value("readout_ready", readout_ready, 1'b1);
                check_value("readout_data", readout_data, held);
            end
            waiting = 1'b0;
            if (readout_ready && readout_trigger) begin
                check_value("readout_data", readout_data, exp_q.pop_front());
                stall = int'(rand_bits(1));
            end else if (readout_ready) begin
                waiting = 1'b1;
                held    = readout_data;
                if (stall > 0) stall--;
            end
        end
        @(posedge clk);
        readout_trigger <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_value("readout_ready", readout_ready, 1'b0);
        end
    endtask

    task automatic run_frame(input int mode);
        int len;
        if (mode == MODE_SKIP) begin
            // Frame already running when the capture starts
            drive_sample(1'b1, 1'b0, pick_pixel());
            request_capture();
            drive_frame(1'b0, `IMG_HEADER_WORDS + 6);
            len = 2 + int'(rand_bits(2));
            repeat (len) drive_sample(1'b0, 1'b0, '0);
        end else begin
            request_capture();
            blank_gap();
            if (mode == MODE_RESTART) begin
                request_capture();
                blank_gap();
            end
        end
        drive_frame(1'b1, 1);
        check_status();
        read_frame();
    endtask

    initial begin
        lfsr            = 32'h74e8;
        fifoIn_rst      = 1'b0;
        cmd_capture     = 1'b0;
        cmd_header      = '0;
        img             = '0;
        readout_trigger = 1'b0;
        pulse_req       = 1'b0;
        next_header     = '0;
        exp_pixels      = 0;
        exp_high        = 0;
        exp_shadow      = 0;

        repeat (3) @(posedge clk);
        fifoIn_rst <= 1'b1;

        @(negedge clk);
        check_value("readout_ready", readout_ready, 1'b0);
        check_value("capture_done", capture_done, 1'b0);
        check_value("pixel_count", 32'(status.pixel_count), 0);
        check_value("highlight_count", 32'(status.highlight_count), 0);
        check_value("shadow_count", 32'(status.shadow_count), 0);

        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f % 3);
        end

        $display("Test passed");
        $finish;
    end

endmodule
